/* Makefile */
SRCS := $(wildcard verilog/*.sv) $(wildcard dv/*.sv) $(wildcard dv/*.svh)

.PHONY: all run clean

all: obj_dir/Vdcache_tb

# rebuilt only when a source or the file list changes
obj_dir/Vdcache_tb: all.f $(SRCS)
	verilator --binary --timing --assert --top-module dcache_tb -f all.f

# exit status of the simulator is the result of the run
run: obj_dir/Vdcache_tb
	./obj_dir/Vdcache_tb

clean:
	rm -rf obj_dir

/* all.f */
+incdir+dv
verilog/dcache_pkg.sv
verilog/line_writeback.sv
verilog/line_refill.sv
verilog/wb_arbiter.sv
verilog/dcache_arrays.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
dv/dcache_tb.sv

/* dv/dcache_tb_util.svh */
`ifndef DCACHE_TB_UTIL_SVH
`define DCACHE_TB_UTIL_SVH

logic [31:0] lfsr_state;
logic [7:0]  model_mem [1024];   // cpu visible bytes

// galois form, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
        return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
endfunction

// one lfsr step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr_state[0]};
        lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
endfunction

function automatic logic [31:0] model_word(input logic [7:0] word_idx);
    return {model_mem[{word_idx, 2'd3}], model_mem[{word_idx, 2'd2}],
            model_mem[{word_idx, 2'd1}], model_mem[{word_idx, 2'd0}]};
endfunction

function automatic void apply_store(input logic [9:0] a, input access_size_e size,
                                    input logic [31:0] wdata);
    int n;
    n = (size == size_byte) ? 1 : ((size == size_half) ? 2 : 4);
    for (int i = 0; i < n; i++) begin
        model_mem[a + 10'(i)] = wdata[i*8 +: 8];   // little endian
    end
endfunction

function automatic logic is_misaligned(input logic [1:0] off, input access_size_e size);
    if (size == size_half) return off[0];
    if (size == size_byte) return 1'b0;
    return off != 2'd0;
endfunction

function automatic logic [31:0] expected_load(input logic [9:0] a, input access_size_e size,
                                              input logic sext);
    logic [31:0] v;
    case (size)
        size_byte: v = {{24{sext & model_mem[a][7]}}, model_mem[a]};
        size_half: v = {{16{sext & model_mem[a + 10'd1][7]}}, model_mem[a + 10'd1], model_mem[a]};
        default:   v = {model_mem[a + 10'd3], model_mem[a + 10'd2], model_mem[a + 10'd1],
                        model_mem[a]};
    endcase
    return v;
endfunction

`endif

/* dv/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb;
    import dcache_pkg::*;

    `include "dcache_tb_util.svh"

    localparam int          num_requests  = 2000;
    localparam int          ready_timeout = 500;
    localparam logic [31:0] resp_timeout  = 32'd500;

    typedef struct packed {
        logic        write;
        logic        misaligned;
        logic [31:0] rdata;
        logic [31:0] addr;
        logic [31:0] accept_cycle;
    } expect_t;

    logic      clk, rst, valid, ready, data_valid;
    cpu_req_t  req;
    cpu_resp_t resp;
    wb_m2s_t   wb_out;
    wb_s2m_t   wb_in;

    logic [31:0] bus_mem [256];   // slave backing store, 1 KB
    logic [63:0] line_stored;     // line written by the cpu since its last writeback
    logic [31:0] cycle_count;
    expect_t     pending_q [$];
    logic        beat_open, group_we;
    logic [1:0]  ack_delay, beat_count;
    logic [27:0] group_line;

    dcache_top dut0 (
        .clk, .rst, .req, .valid, .ready, .resp, .data_valid, .wb_out, .wb_in
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_beat();
        logic [7:0]  word_idx;
        logic [31:0] exp_word;
        word_idx = wb_out.adr[9:2];
        assert (wb_out.adr[31:10] == 22'd0)
            else fail_run($sformatf("bus address %h is outside the memory", wb_out.adr));
        assert (wb_out.sel == 4'hf)
            else fail_run($sformatf("Mismatch wb_out.sel: got %h expected f", wb_out.sel));
        if (beat_count == 2'd0) begin
            group_line = wb_out.adr[31:4];
            group_we   = wb_out.we;
        end
        assert (wb_out.adr[31:4] == group_line && wb_out.adr[3:2] == beat_count
                && wb_out.we == group_we)
            else fail_run($sformatf("beat at %h breaks the 4-beat line order", wb_out.adr));
        if (wb_out.we) begin
            exp_word = model_word(word_idx);
            assert (wb_out.dat == exp_word)
                else fail_run($sformatf("Mismatch wb_out.dat at %h: got %h expected %h",
                                        wb_out.adr, wb_out.dat, exp_word));
            assert (line_stored[word_idx[7:2]])
                else fail_run($sformatf("line at %h written back without a store", wb_out.adr));
            bus_mem[word_idx] = wb_out.dat;
            if (beat_count == 2'd3) line_stored[word_idx[7:2]] = 1'b0;
        end else begin
            wb_in.dat = bus_mem[word_idx];
        end
        beat_count = beat_count + 2'd1;
    endtask

    // wishbone classic slave with 0 to 3 wait cycles per beat
    task automatic serve_memory();
        assert (wb_out.cyc || !wb_out.stb) else fail_run("stb is high while cyc is low");
        if (wb_in.ack) begin
            wb_in.ack = 1'b0;   // beat taken at the last rising edge
        end else if (wb_out.cyc && wb_out.stb) begin
            if (!beat_open) begin
                beat_open = 1'b1;
                ack_delay = 2'(rand_bits(2));
            end
            if (ack_delay != 2'd0) begin
                ack_delay = ack_delay - 2'd1;
            end else begin
                beat_open = 1'b0;
                check_beat();
                wb_in.ack = 1'b1;
            end
        end else begin
            assert (beat_count == 2'd0) else fail_run("cyc dropped inside a 4-beat line");
        end
    endtask

    task automatic check_response();
        expect_t e;
        if (data_valid) begin
            assert (pending_q.size() != 0) else fail_run("data_valid without a request");
            e = pending_q.pop_front();
            assert (resp.misaligned == e.misaligned)
                else fail_run($sformatf("Mismatch resp.misaligned at %h: got %h expected %h",
                                        e.addr, resp.misaligned, e.misaligned));
            if (!e.write && !e.misaligned) begin
                assert (resp.rdata == e.rdata)
                    else fail_run($sformatf("Mismatch resp.rdata at %h: got %h expected %h",
                                            e.addr, resp.rdata, e.rdata));
            end
        end
        if (pending_q.size() != 0) begin
            e = pending_q[0];
            assert (cycle_count - e.accept_cycle < resp_timeout)
                else fail_run($sformatf("no data_valid for the request at %h", e.addr));
        end
    endtask

    task automatic tick();
        @(negedge clk);
        cycle_count = cycle_count + 32'd1;
        serve_memory();
        check_response();
    endtask

    task automatic send_request();
        cpu_req_t    r;
        expect_t     e;
        logic [1:0]  s;
        logic [31:0] a;
        int          waited;
        r.write      = 1'(rand_bits(1));
        s            = 2'(rand_bits(2));
        r.size       = (s == 2'd3) ? size_word : access_size_e'(s);
        r.signed_ext = 1'(rand_bits(1));
        a            = rand_bits(9);   // 8 sets and 4 tags, a 512-byte window
        a            = {22'd0, a[8:7], 1'b0, a[6:0]};
        if (r.size == size_half) a[0] = 1'b0;
        if (r.size == size_word) a[1:0] = 2'd0;
        if (4'(rand_bits(4)) == 4'd0) begin
            s = 2'(rand_bits(2));
            if (r.size == size_half) a[0] = 1'b1;
            if (r.size == size_word) a[1:0] = (s == 2'd0) ? 2'd2 : s;
        end
        r.addr.raw = a;
        r.wdata    = rand_bits(32);
        waited = 0;
        while (!ready) begin
            assert (waited < ready_timeout) else fail_run("ready stayed low too long");
            tick();
            waited++;
        end
        e.write        = r.write;
        e.misaligned   = is_misaligned(a[1:0], r.size);
        e.rdata        = expected_load(a[9:0], r.size, r.signed_ext);
        e.addr         = a;
        e.accept_cycle = cycle_count;
        if (r.write && !e.misaligned) begin
            apply_store(a[9:0], r.size, r.wdata);
            line_stored[a[9:4]] = 1'b1;
        end
        pending_q.push_back(e);
        req   = r;
        valid = 1'b1;
        tick();           // accepted at the rising edge inside this cycle
        valid = 1'b0;
    endtask

    initial begin
        int          waited;
        logic [31:0] word;
        rst         = 1'b1;
        valid       = 1'b0;
        req         = '0;
        wb_in       = '0;
        lfsr_state  = 32'd24;
        line_stored = '0;
        cycle_count = '0;
        beat_open   = 1'b0;
        ack_delay   = 2'd0;
        beat_count  = 2'd0;
        group_we    = 1'b0;
        group_line  = '0;
        for (int w = 0; w < 256; w++) begin
            word       = rand_bits(32);
            bus_mem[w] = word;
            for (int b = 0; b < 4; b++) model_mem[w*4 + b] = word[b*8 +: 8];
        end
        repeat (3) tick();
        rst = 1'b0;
        assert (ready && !data_valid && !wb_out.cyc) else fail_run("outputs wrong after reset");
        for (int n = 0; n < num_requests; n++) begin
            if (3'(rand_bits(3)) == 3'd0) tick();   // idle gap now and then
            send_request();
        end
        waited = 0;
        while (pending_q.size() != 0) begin
            assert (waited < ready_timeout) else fail_run("last responses never arrived");
            tick();
            waited++;
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* verilog/dcache_arrays.sv */
`timescale 1ns/1ps

module dcache_arrays (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [dcache_pkg::index_bits-1:0] rd_index,
    output logic [dcache_pkg::num_ways-1:0][dcache_pkg::tag_bits-1:0] rd_tags,
    output logic [dcache_pkg::num_ways-1:0] rd_valid,
    output logic [dcache_pkg::num_ways-1:0] rd_dirty,
    output dcache_pkg::cache_line_t [dcache_pkg::num_ways-1:0] rd_lines,
    output logic                      rd_lru,
    input  logic                      wr_en,
    input  logic                      wr_way,
    input  logic [dcache_pkg::index_bits-1:0] wr_index,
    input  dcache_pkg::cache_line_t   wr_line,
    input  logic [15:0]               wr_byte_en,
    input  logic [dcache_pkg::tag_bits-1:0] wr_tag,
    input  logic                      wr_valid,
    input  logic                      wr_dirty,
    input  logic                      wr_lru
);
    import dcache_pkg::*;

    logic [tag_bits-1:0] tags  [num_ways][num_sets];
    cache_line_t         lines [num_ways][num_sets];
    logic [num_ways-1:0][num_sets-1:0] valid_q;
    logic [num_ways-1:0][num_sets-1:0] dirty_q;
    logic [num_sets-1:0] lru_q;   // way to replace next

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            rd_tags[w]  = tags[w][rd_index];
            rd_lines[w] = lines[w][rd_index];
            rd_valid[w] = valid_q[w][rd_index];
            rd_dirty[w] = dirty_q[w][rd_index];
        end
    end
    assign rd_lru = lru_q[rd_index];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else if (wr_en) begin
            valid_q[wr_way][wr_index] <= wr_valid;
            dirty_q[wr_way][wr_index] <= wr_dirty;
            lru_q[wr_index]           <= wr_lru;
        end
    end

    // tag and data, byte granular
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tags[wr_way][wr_index] <= wr_tag;
            for (int b = 0; b < 16; b++) begin
                if (wr_byte_en[b]) begin
                    lines[wr_way][wr_index][b/4][(b%4)*8 +: 8] <= wr_line[b/4][(b%4)*8 +: 8];
                end
            end
        end
    end

    // partial writes only merge into a line already held
    assert property (@(posedge clk) disable iff (rst)
        wr_en && wr_byte_en != '1 |-> valid_q[wr_way][wr_index]
                                      && tags[wr_way][wr_index] == wr_tag);

endmodule

/* verilog/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  dcache_pkg::cpu_req_t      req,
    input  logic                      valid,
    output logic                      ready,
    output dcache_pkg::cpu_resp_t     resp,
    output logic                      data_valid,
    output logic [dcache_pkg::index_bits-1:0] rd_index,
    input  logic [dcache_pkg::num_ways-1:0][dcache_pkg::tag_bits-1:0] rd_tags,
    input  logic [dcache_pkg::num_ways-1:0] rd_valid,
    input  logic [dcache_pkg::num_ways-1:0] rd_dirty,
    input  dcache_pkg::cache_line_t [dcache_pkg::num_ways-1:0] rd_lines,
    input  logic                      rd_lru,
    output logic                      wr_en,
    output logic                      wr_way,
    output logic [dcache_pkg::index_bits-1:0] wr_index,
    output dcache_pkg::cache_line_t   wr_line,
    output logic [15:0]               wr_byte_en,
    output logic [dcache_pkg::tag_bits-1:0] wr_tag,
    output logic                      wr_valid,
    output logic                      wr_dirty,
    output logic                      wr_lru,
    output logic                      wbk_load,
    output dcache_pkg::cache_line_t   wbk_line,
    output logic [31:0]               wbk_addr,
    input  logic                      wbk_busy,
    output logic                      fill_start,
    output logic [31:0]               fill_addr,
    input  logic                      fill_done,
    input  dcache_pkg::cache_line_t   fill_line
);
    import dcache_pkg::*;

    typedef enum logic [1:0] {s_run, s_evict, s_start, s_fill} state_e;

    state_e      state;
    cpu_req_t    rq;          // buffered request
    logic        pending;
    logic        victim;
    logic [num_ways-1:0] way_hit;
    logic        hit, hit_way, misaligned, miss, need_wb, pick;
    logic [3:0]  word_en;
    logic [15:0] store_en;
    logic [31:0] store_word, shifted;
    cache_line_t src_line, merged;

    assign rd_index = rq.addr.f.index;
    assign wr_index = rq.addr.f.index;

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            way_hit[w] = rd_valid[w] && (rd_tags[w] == rq.addr.f.tag);
        end
    end
    assign hit     = |way_hit;
    assign hit_way = way_hit[1];

    // decode size into lane enables and replicated store data
    always_comb begin
        case (rq.size)
            size_byte: begin
                misaligned = 1'b0;
                word_en    = 4'b0001 << rq.addr.f.byte_off;
                store_word = {4{rq.wdata[7:0]}};
            end
            size_half: begin
                misaligned = rq.addr.f.byte_off[0];
                word_en    = 4'b0011 << rq.addr.f.byte_off;
                store_word = {2{rq.wdata[15:0]}};
            end
            default: begin
                misaligned = rq.addr.f.byte_off != 2'd0;
                word_en    = 4'b1111;
                store_word = rq.wdata;
            end
        endcase
    end

    assign store_en = rq.write ? (16'(word_en) << {rq.addr.f.word_off, 2'b00}) : 16'd0;
    assign miss     = pending && !misaligned && !hit;
    assign ready    = (state == s_run) && !miss;

    // invalid way first, else lru
    assign pick    = !rd_valid[0] ? 1'b0 : (!rd_valid[1] ? 1'b1 : rd_lru);
    assign need_wb = rd_valid[victim] && rd_dirty[victim];

    assign wbk_line  = rd_lines[victim];
    assign wbk_addr  = {rd_tags[victim], rq.addr.f.index, 4'b0000};
    assign fill_addr = {rq.addr.f.tag, rq.addr.f.index, 4'b0000};

    // load path, the refilled line stands in for the array on a miss
    assign src_line = (state == s_fill) ? fill_line : rd_lines[hit_way];
    assign shifted  = src_line[rq.addr.f.word_off] >> {rq.addr.f.byte_off, 3'b000};

    always_comb begin
        case (rq.size)
            size_byte: resp.rdata = {{24{rq.signed_ext & shifted[7]}}, shifted[7:0]};
            size_half: resp.rdata = {{16{rq.signed_ext & shifted[15]}}, shifted[15:0]};
            default:   resp.rdata = shifted;
        endcase
        resp.misaligned = misaligned;
    end

    always_comb begin
        for (int b = 0; b < 16; b++) begin
            merged[b/4][(b%4)*8 +: 8] = store_en[b] ? store_word[(b%4)*8 +: 8]
                                                    : fill_line[b/4][(b%4)*8 +: 8];
        end
    end

    always_comb begin
        data_valid = 1'b0;
        wr_en      = 1'b0;
        wr_way     = hit_way;
        wr_line    = {line_words{store_word}};
        wr_byte_en = store_en;         // zero on a load hit, lru only
        wr_tag     = rq.addr.f.tag;
        wr_valid   = 1'b1;
        wr_dirty   = rd_dirty[hit_way] | rq.write;
        wr_lru     = !hit_way;
        wbk_load   = 1'b0;
        fill_start = 1'b0;
        case (state)
            s_run: begin
                if (pending && (misaligned || hit)) begin
                    data_valid = 1'b1;
                    wr_en      = !misaligned;
                end
            end
            s_evict: begin
                if (!need_wb) fill_start = 1'b1;
                else if (!wbk_busy) wbk_load = 1'b1;
            end
            s_start: fill_start = 1'b1;
            s_fill: begin
                if (fill_done) begin
                    data_valid = 1'b1;
                    wr_en      = 1'b1;
                    wr_way     = victim;
                    wr_line    = merged;
                    wr_byte_en = '1;
                    wr_dirty   = rq.write;
                    wr_lru     = !victim;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= s_run;
            pending <= 1'b0;
            victim  <= 1'b0;
        end else begin
            case (state)
                s_run: begin
                    if (miss) begin
                        state  <= s_evict;
                        victim <= pick;
                    end else begin
                        pending <= valid;
                    end
                end
                s_evict: begin
                    if (!need_wb) state <= s_fill;
                    else if (!wbk_busy) state <= s_start;
                end
                s_start: state <= s_fill;
                s_fill: begin
                    if (fill_done) begin
                        state   <= s_run;
                        pending <= 1'b0;
                    end
                end
                default: state <= s_run;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (valid && ready) rq <= req;
    end

    assert property (@(posedge clk) disable iff (rst) data_valid |-> pending);

    // one refill at a time
    assert property (@(posedge clk) disable iff (rst)
        fill_start |=> (!fill_start throughout fill_done[->1]));

endmodule

/* verilog/dcache_pkg.sv */
package dcache_pkg;

    // cache geometry
    localparam int num_ways   = 2;
    localparam int num_sets   = 16;
    localparam int line_words = 4;
    localparam int index_bits = $clog2(num_sets);
    localparam int tag_bits   = 32 - index_bits - 4;   // 4 bits of line offset

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } access_size_e;

    typedef struct packed {
        logic [tag_bits-1:0]   tag;
        logic [index_bits-1:0] index;
        logic [1:0]            word_off;
        logic [1:0]            byte_off;
    } addr_fields_t;

    // cpu address, read raw or split into fields
    typedef union packed {
        logic [31:0]  raw;
        addr_fields_t f;
    } cache_addr_u;

    typedef struct packed {
        logic         write;
        access_size_e size;
        logic         signed_ext;
        cache_addr_u  addr;
        logic [31:0]  wdata;     // low justified
    } cpu_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        misaligned;
    } cpu_resp_t;

    typedef logic [line_words-1:0][31:0] cache_line_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
    } wb_m2s_t;

    typedef struct packed {
        logic [31:0] dat;
        logic        ack;
    } wb_s2m_t;

endpackage

/* verilog/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top (
    input  logic                 clk,
    input  logic                 rst,
    input  dcache_pkg::cpu_req_t req,
    input  logic                 valid,
    output logic                 ready,
    output dcache_pkg::cpu_resp_t resp,
    output logic                 data_valid,
    output dcache_pkg::wb_m2s_t  wb_out,
    input  dcache_pkg::wb_s2m_t  wb_in
);
    import dcache_pkg::*;

    // array read side
    logic [index_bits-1:0]                rd_index;
    logic [num_ways-1:0][tag_bits-1:0]    rd_tags;
    logic [num_ways-1:0]                  rd_valid;
    logic [num_ways-1:0]                  rd_dirty;
    cache_line_t [num_ways-1:0]           rd_lines;
    logic                                 rd_lru;

    // array write side
    logic                  wr_en;
    logic                  wr_way;
    logic [index_bits-1:0] wr_index;
    cache_line_t           wr_line;
    logic [15:0]           wr_byte_en;
    logic [tag_bits-1:0]   wr_tag;
    logic                  wr_valid;
    logic                  wr_dirty;
    logic                  wr_lru;

    logic        wbk_load, wbk_busy, wbk_ack;
    cache_line_t wbk_line;
    logic [31:0] wbk_addr;
    logic        fill_start, fill_done, fill_ack;
    logic [31:0] fill_addr;
    cache_line_t fill_line;
    wb_m2s_t     wbk_bus, fill_bus;
    wb_s2m_t     fill_in;

    assign fill_in = '{dat: wb_in.dat, ack: fill_ack};   // read data is shared

    dcache_ctrl ctrl0 (
        .clk, .rst, .req, .valid, .ready, .resp, .data_valid,
        .rd_index, .rd_tags, .rd_valid, .rd_dirty, .rd_lines, .rd_lru,
        .wr_en, .wr_way, .wr_index, .wr_line, .wr_byte_en,
        .wr_tag, .wr_valid, .wr_dirty, .wr_lru,
        .wbk_load, .wbk_line, .wbk_addr, .wbk_busy,
        .fill_start, .fill_addr, .fill_done, .fill_line
    );

    dcache_arrays arrays0 (
        .clk, .rst,
        .rd_index, .rd_tags, .rd_valid, .rd_dirty, .rd_lines, .rd_lru,
        .wr_en, .wr_way, .wr_index, .wr_line, .wr_byte_en,
        .wr_tag, .wr_valid, .wr_dirty, .wr_lru
    );

    line_writeback wbk0 (
        .clk, .rst, .load(wbk_load), .line_in(wbk_line), .line_addr(wbk_addr),
        .busy(wbk_busy), .wb_out(wbk_bus), .wb_ack(wbk_ack)
    );

    line_refill fill0 (
        .clk, .rst, .start(fill_start), .line_addr(fill_addr), .done(fill_done),
        .line_out(fill_line), .wb_out(fill_bus), .wb_in(fill_in)
    );

    wb_arbiter arb0 (
        .clk, .rst, .wbk_bus, .fill_bus, .wbk_ack, .fill_ack, .wb_out, .wb_in
    );

endmodule

/* verilog/line_refill.sv */
`timescale 1ns/1ps

module line_refill (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  logic [31:0]             line_addr,
    output logic                    done,
    output dcache_pkg::cache_line_t line_out,
    output dcache_pkg::wb_m2s_t     wb_out,
    input  dcache_pkg::wb_s2m_t     wb_in
);
    import dcache_pkg::*;

    logic        active;
    logic [1:0]  beat;
    logic [31:0] addr_q;
    cache_line_t line_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            beat   <= 2'd0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                active <= 1'b1;
                beat   <= 2'd0;
            end else if (active && wb_in.ack) begin
                beat <= beat + 2'd1;
                if (beat == 2'd3) begin
                    active <= 1'b0;
                    done   <= 1'b1;   // line complete next cycle
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) addr_q <= line_addr;
        if (active && wb_in.ack) line_q[beat] <= wb_in.dat;
    end

    assign line_out = line_q;

    always_comb begin
        wb_out.cyc = active;
        wb_out.stb = active;
        wb_out.we  = 1'b0;
        wb_out.adr = {addr_q[31:4], beat, 2'b00};
        wb_out.dat = 32'd0;
        wb_out.sel = 4'hf;
    end

    assert property (@(posedge clk) disable iff (rst) start |-> !active);

endmodule

/* verilog/line_writeback.sv */
`timescale 1ns/1ps

module line_writeback (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    load,
    input  dcache_pkg::cache_line_t line_in,
    input  logic [31:0]             line_addr,
    output logic                    busy,
    output dcache_pkg::wb_m2s_t     wb_out,
    input  logic                    wb_ack
);
    import dcache_pkg::*;

    cache_line_t line_q;
    logic [31:0] addr_q;
    logic [1:0]  beat;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            beat <= 2'd0;
        end else if (load) begin
            busy <= 1'b1;
            beat <= 2'd0;
        end else if (busy && wb_ack) begin
            beat <= beat + 2'd1;
            if (beat == 2'd3) busy <= 1'b0;    // last beat
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            line_q <= line_in;
            addr_q <= line_addr;
        end
    end

    always_comb begin
        wb_out.cyc = busy;
        wb_out.stb = busy;
        wb_out.we  = 1'b1;
        wb_out.adr = {addr_q[31:4], beat, 2'b00};
        wb_out.dat = line_q[beat];
        wb_out.sel = 4'hf;
    end

endmodule

/* verilog/wb_arbiter.sv */
`timescale 1ns/1ps

module wb_arbiter (
    input  logic                clk,
    input  logic                rst,
    input  dcache_pkg::wb_m2s_t wbk_bus,
    input  dcache_pkg::wb_m2s_t fill_bus,
    output logic                wbk_ack,
    output logic                fill_ack,
    output dcache_pkg::wb_m2s_t wb_out,
    input  dcache_pkg::wb_s2m_t wb_in
);

    logic locked;
    logic owner;     // 0 writeback, 1 refill

    always_ff @(posedge clk) begin
        if (rst) begin
            locked <= 1'b0;
            owner  <= 1'b0;
        end else if (!locked) begin
            // idle bus, writeback first
            if (wbk_bus.cyc) begin
                locked <= 1'b1;
                owner  <= 1'b0;
            end else if (fill_bus.cyc) begin
                locked <= 1'b1;
                owner  <= 1'b1;
            end
        end else if (!(owner ? fill_bus.cyc : wbk_bus.cyc)) begin
            locked <= 1'b0;   // holder dropped cyc
        end
    end

    always_comb begin
        if (!locked) wb_out = '0;
        else if (owner) wb_out = fill_bus;
        else wb_out = wbk_bus;
    end

    assign wbk_ack  = locked && !owner && wb_in.ack;
    assign fill_ack = locked && owner && wb_in.ack;

    // granted beat held on the bus until ack
    assert property (@(posedge clk) disable iff (rst)
        wb_out.stb && !wb_in.ack |=> $stable(wb_out));

endmodule
